//--- iadc_pkg.sv
package iadc_pkg;

  // register index, taken from bus address bits 4 to 1
  typedef enum logic [3:0] {
    REG_RESET       = 4'd0,  // write strobes adc_ddrb
    REG_MODE        = 4'd1,  // interleave mode level
    REG_TWI_ADDR    = 4'd2,
    REG_TWI_DATA    = 4'd3,
    REG_TWI_TX      = 4'd4,  // write starts transfer, read gives busy
    REG_FIFODATA_4  = 4'd5,  // sync and out-of-range bits
    REG_FIFODATA_3  = 4'd6,
    REG_FIFODATA_2  = 4'd7,
    REG_FIFODATA_1  = 4'd8,
    REG_FIFODATA_0  = 4'd9,  // lowest data halfword
    REG_FIFO_ADV    = 4'd10, // bit 0 pops one entry
    REG_FIFO_STATUS = 4'd11,
    REG_FIFO_CTRL   = 4'd12, // capture enable
    REG_CLKTEST1    = 4'd13,
    REG_CLKTEST0    = 4'd14
  } iadc_reg_e;

  // three-wire config word
  // 3 address bits on top of 16 data bits
  localparam int TWI_WORD_W = 19;

  // one captured sample
  // {sync, outofrange[3:0], data[63:0]}
  localparam int SAMPLE_W = 69;

endpackage

//--- iadc_if.sv
`timescale 1ns/1ps

// config word and transfer strobe toward the serializer
interface twi_cfg_if import iadc_pkg::*; ();
  localparam int TWI_ADDR_W = 3;

  logic [TWI_ADDR_W-1:0]            twi_addr;
  logic [TWI_WORD_W-TWI_ADDR_W-1:0] twi_data;
  logic                             tx_strb;  // single cycle
  logic                             busy;     // high for the whole transfer

  modport master (
    output twi_addr,
    output twi_data,
    output tx_strb,
    input  busy
  );

  modport slave (
    input  twi_addr,
    input  twi_data,
    input  tx_strb,
    output busy
  );
endinterface

// read side of the sample fifo
interface sample_rd_if import iadc_pkg::*; ();
  logic [SAMPLE_W-1:0] rd_data;  // oldest entry, shown ahead of the pop
  logic                rd_strb;
  logic                empty;
  logic                almost_empty;
  logic                almost_full;
  logic                full;

  modport reader (
    input  rd_data,
    input  empty,
    input  almost_empty,
    input  almost_full,
    input  full,
    output rd_strb
  );

  modport fifo (
    output rd_data,
    output empty,
    output almost_empty,
    output almost_full,
    output full,
    input  rd_strb
  );
endinterface

//--- iadc_regs.sv
`timescale 1ns/1ps

module iadc_regs import iadc_pkg::*; (
  input  logic        adc_clk_0,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        adc_mode_o,
  output logic        adc_ddrb_o,
  output logic        fifo_enable_o,
  twi_cfg_if.master   twi_cfg,
  sample_rd_if.reader sample_rd
);

  iadc_reg_e   reg_idx;
  iadc_reg_e   dat_src;     // read source, latched at ack
  logic        bus_req;
  logic        ack_q;
  logic        mode_q;
  logic        ddrb_q;
  logic        fifo_enable_q;
  logic [2:0]  twi_addr_q;
  logic [15:0] twi_data_q;
  logic        tx_strb_q;
  logic        rd_strb_q;
  logic [31:0] clk_counter; // activity counter

  assign reg_idx = iadc_reg_e'(wb_adr_i[4:1]);
  assign bus_req = wb_cyc_i & wb_stb_i & ~ack_q;

  always_ff @(posedge adc_clk_0) begin
    if (wb_rst_i) begin
      ack_q         <= 1'b0;
      dat_src       <= REG_RESET;
      mode_q        <= 1'b0;
      ddrb_q        <= 1'b0;
      fifo_enable_q <= 1'b0;
      twi_addr_q    <= 3'b0;
      twi_data_q    <= 16'b0;
      tx_strb_q     <= 1'b0;
      rd_strb_q     <= 1'b0;
    end else begin
      ack_q     <= bus_req;
      ddrb_q    <= 1'b0;  // strobes default low
      tx_strb_q <= 1'b0;
      rd_strb_q <= 1'b0;
      if (bus_req) begin
        dat_src <= reg_idx;
        if (wb_we_i) begin
          case (reg_idx)
            REG_RESET: begin
              if (wb_sel_i[0])
                ddrb_q <= 1'b1;
            end
            REG_MODE: begin
              if (wb_sel_i[0])
                mode_q <= wb_dat_i[0];
            end
            REG_TWI_ADDR: begin
              if (wb_sel_i[0])
                twi_addr_q <= wb_dat_i[2:0];
            end
            REG_TWI_DATA: begin
              if (wb_sel_i[1])
                twi_data_q[15:8] <= wb_dat_i[15:8];
              if (wb_sel_i[0])
                twi_data_q[7:0] <= wb_dat_i[7:0];
            end
            REG_TWI_TX: begin
              if (wb_sel_i[0])
                tx_strb_q <= 1'b1; // shifter drops it if busy
            end
            REG_FIFO_ADV: begin
              if (wb_sel_i[0])
                rd_strb_q <= wb_dat_i[0];
            end
            REG_FIFO_CTRL: begin
              if (wb_sel_i[0])
                fifo_enable_q <= wb_dat_i[0];
            end
            default: ;  // read-only entries
          endcase
        end
      end
    end
  end

  always_ff @(posedge adc_clk_0) begin
    if (wb_rst_i)
      clk_counter <= 32'b0;
    else
      clk_counter <= clk_counter + 32'd1;
  end

  // read data follows the latched source while ack is up
  always_comb begin
    case (dat_src)
      REG_RESET:       wb_dat_o = {15'b0, ddrb_q};
      REG_MODE:        wb_dat_o = {15'b0, mode_q};
      REG_TWI_ADDR:    wb_dat_o = {13'b0, twi_addr_q};
      REG_TWI_DATA:    wb_dat_o = twi_data_q;
      REG_TWI_TX:      wb_dat_o = {15'b0, twi_cfg.busy};
      REG_FIFODATA_4:  wb_dat_o = {11'b0, sample_rd.rd_data[68:64]};
      REG_FIFODATA_3:  wb_dat_o = sample_rd.rd_data[63:48];
      REG_FIFODATA_2:  wb_dat_o = sample_rd.rd_data[47:32];
      REG_FIFODATA_1:  wb_dat_o = sample_rd.rd_data[31:16];
      REG_FIFODATA_0:  wb_dat_o = sample_rd.rd_data[15:0];
      REG_FIFO_STATUS: wb_dat_o = {12'b0, sample_rd.full, sample_rd.almost_full,
                                   sample_rd.almost_empty, sample_rd.empty};
      REG_FIFO_CTRL:   wb_dat_o = {15'b0, fifo_enable_q};
      REG_CLKTEST1:    wb_dat_o = clk_counter[31:16];
      REG_CLKTEST0:    wb_dat_o = clk_counter[15:0];
      default:         wb_dat_o = 16'b0; // fifo_adv and unused index
    endcase
  end

  assign wb_ack_o          = ack_q;
  assign adc_mode_o        = mode_q;
  assign adc_ddrb_o        = ddrb_q;
  assign fifo_enable_o     = fifo_enable_q;
  assign twi_cfg.twi_addr  = twi_addr_q;
  assign twi_cfg.twi_data  = twi_data_q;
  assign twi_cfg.tx_strb   = tx_strb_q;
  assign sample_rd.rd_strb = rd_strb_q;

endmodule

//--- twi_shifter.sv
`timescale 1ns/1ps

module twi_shifter import iadc_pkg::*; #(
  parameter int TWI_DIV_LOG2 = 7
) (
  input  logic     adc_clk_0,
  input  logic     wb_rst_i,
  twi_cfg_if.slave twi_cfg,
  output logic     adc_ctrl_clk_o,
  output logic     adc_ctrl_data_o,
  output logic     adc_ctrl_strobe_n_o
);

  // progress steps, one per serial clock period
  localparam logic [4:0] PROG_IDLE   = 5'd0;
  localparam logic [4:0] PROG_WAIT   = 5'd1;  // align to the divider
  localparam logic [4:0] PROG_FIRST  = 5'd2;  // first data bit
  localparam logic [4:0] PROG_COMMIT = 5'(TWI_WORD_W + 2);
  localparam logic [4:0] PROG_END    = 5'(TWI_WORD_W + 3);

  logic [TWI_DIV_LOG2-1:0] div_cnt;
  logic                    div_wrap;
  logic [4:0]              progress;
  logic [TWI_WORD_W-1:0]   shift_reg;
  logic                    shift_phase;

  assign div_wrap    = &div_cnt;
  assign shift_phase = (progress >= PROG_FIRST) && (progress < PROG_COMMIT);

  always_ff @(posedge adc_clk_0) begin
    if (wb_rst_i) begin
      div_cnt   <= '0;
      progress  <= PROG_IDLE;
      shift_reg <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;  // free running
      if (progress == PROG_IDLE) begin
        if (twi_cfg.tx_strb) begin
          progress  <= PROG_WAIT;
          shift_reg <= {twi_cfg.twi_addr, twi_cfg.twi_data};
        end
      end else if (div_wrap) begin
        case (progress)
          PROG_WAIT:   progress <= PROG_FIRST;
          PROG_COMMIT: progress <= PROG_END;
          PROG_END:    progress <= PROG_IDLE;
          default: begin
            shift_reg <= {shift_reg[TWI_WORD_W-2:0], 1'b0}; // msb first
            progress  <= progress + 5'd1;
          end
        endcase
      end
    end
  end

  assign twi_cfg.busy = progress != PROG_IDLE;

  // low first half, rising mid-bit where the adc samples
  assign adc_ctrl_clk_o      = shift_phase ? div_cnt[TWI_DIV_LOG2-1] : 1'b1;
  assign adc_ctrl_data_o     = shift_reg[TWI_WORD_W-1];
  assign adc_ctrl_strobe_n_o = (progress == PROG_IDLE) || (progress == PROG_END);

endmodule

//--- adc_capture.sv
`timescale 1ns/1ps

module adc_capture import iadc_pkg::*; (
  input  logic                adc_clk_0,
  input  logic                wb_rst_i,
  input  logic [63:0]         adc_data_i,
  input  logic [3:0]          adc_outofrange_i,
  input  logic                adc_sync_i,
  input  logic                fifo_enable_i,
  output logic [SAMPLE_W-1:0] wr_data_o,
  output logic                wr_en_o,
  output logic                fifo_clear_o
);

  logic enable_q;  // enable one cycle late

  // sample register, loaded every clock
  always_ff @(posedge adc_clk_0) begin
    wr_data_o <= {adc_sync_i, adc_outofrange_i, adc_data_i};
  end

  always_ff @(posedge adc_clk_0) begin
    if (wb_rst_i)
      enable_q <= 1'b0;
    else
      enable_q <= fifo_enable_i;
  end

  assign wr_en_o = enable_q;  // lines up with the registered sample

  // clear lands one edge before the first write
  assign fifo_clear_o = fifo_enable_i & ~enable_q;

endmodule

//--- sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo import iadc_pkg::*; #(
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic                adc_clk_0,
  input  logic                wb_rst_i,
  input  logic                clear_i,
  input  logic                wr_en_i,
  input  logic [SAMPLE_W-1:0] wr_data_i,
  sample_rd_if.fifo           sample_rd
);

  localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;
  localparam int CNT_W = FIFO_DEPTH_LOG2 + 1;

  typedef logic [CNT_W-1:0] cnt_t;

  logic [SAMPLE_W-1:0]        mem [DEPTH];
  logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
  cnt_t                       count;
  logic                       do_wr;
  logic                       do_rd;

  assign do_wr = wr_en_i & ~sample_rd.full;           // overflow dropped
  assign do_rd = sample_rd.rd_strb & ~sample_rd.empty; // underflow ignored

  always_ff @(posedge adc_clk_0) begin
    if (do_wr)
      mem[wr_ptr] <= wr_data_i;
  end

  always_ff @(posedge adc_clk_0) begin
    if (wb_rst_i || clear_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // both or neither
      endcase
    end
  end

  // show-ahead read port
  assign sample_rd.rd_data = mem[rd_ptr];

  assign sample_rd.empty        = count == '0;
  assign sample_rd.full         = count == cnt_t'(DEPTH);
  assign sample_rd.almost_empty = count <= cnt_t'(2);
  assign sample_rd.almost_full  = count >= cnt_t'(DEPTH - 2);

endmodule

//--- iadc_top.sv
`timescale 1ns/1ps

module iadc_top import iadc_pkg::*; #(
  parameter int TWI_DIV_LOG2    = 7,
  parameter int FIFO_DEPTH_LOG2 = 4
) (
  input  logic        adc_clk_0,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic [63:0] adc_data_i,
  input  logic [3:0]  adc_outofrange_i,
  input  logic        adc_sync_i,
  output logic        adc_ctrl_clk_o,
  output logic        adc_ctrl_data_o,
  output logic        adc_ctrl_strobe_n_o,
  output logic        adc_mode_o,
  output logic        adc_ddrb_o
);

  logic                fifo_enable;
  logic                fifo_clear;
  logic                fifo_wr_en;
  logic [SAMPLE_W-1:0] fifo_wr_data;

  twi_cfg_if   twi_cfg ();
  sample_rd_if sample_rd ();

  iadc_regs u_regs (
    .adc_clk_0     (adc_clk_0),
    .wb_rst_i      (wb_rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .adc_mode_o    (adc_mode_o),
    .adc_ddrb_o    (adc_ddrb_o),
    .fifo_enable_o (fifo_enable),
    .twi_cfg       (twi_cfg.master),
    .sample_rd     (sample_rd.reader)
  );

  twi_shifter #(
    .TWI_DIV_LOG2 (TWI_DIV_LOG2)
  ) u_twi (
    .adc_clk_0           (adc_clk_0),
    .wb_rst_i            (wb_rst_i),
    .twi_cfg             (twi_cfg.slave),
    .adc_ctrl_clk_o      (adc_ctrl_clk_o),
    .adc_ctrl_data_o     (adc_ctrl_data_o),
    .adc_ctrl_strobe_n_o (adc_ctrl_strobe_n_o)
  );

  adc_capture u_capture (
    .adc_clk_0        (adc_clk_0),
    .wb_rst_i         (wb_rst_i),
    .adc_data_i       (adc_data_i),
    .adc_outofrange_i (adc_outofrange_i),
    .adc_sync_i       (adc_sync_i),
    .fifo_enable_i    (fifo_enable),
    .wr_data_o        (fifo_wr_data),
    .wr_en_o          (fifo_wr_en),
    .fifo_clear_o     (fifo_clear)
  );

  sample_fifo #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) u_fifo (
    .adc_clk_0 (adc_clk_0),
    .wb_rst_i  (wb_rst_i),
    .clear_i   (fifo_clear),
    .wr_en_i   (fifo_wr_en),
    .wr_data_i (fifo_wr_data),
    .sample_rd (sample_rd.fifo)
  );

endmodule

//--- iadc_checker.sv
`timescale 1ns/1ps

module iadc_checker (
  input logic adc_clk_0,
  input logic wb_rst_i,
  input logic ack_i,
  input logic mode_i,
  input logic ddrb_i,
  input logic ctrl_clk_i,
  input logic strobe_n_i
);

  int fail_cnt = 0;

  ack_one_cycle: assert property (@(posedge adc_clk_0) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o stayed high for more than one cycle");
    end

  ddrb_one_cycle: assert property (@(posedge adc_clk_0) disable iff (wb_rst_i)
    ddrb_i |=> !ddrb_i)
    else begin
      fail_cnt++;
      $error("adc_ddrb_o stayed high for more than one cycle");
    end

  // ddrb pulse sits on the ack of its write
  ddrb_with_ack: assert property (@(posedge adc_clk_0) disable iff (wb_rst_i)
    ddrb_i |-> ack_i)
    else begin
      fail_cnt++;
      $error("adc_ddrb_o high without a bus ack");
    end

  // serial clock parked high while the adc is not selected
  clk_idle_high: assert property (@(posedge adc_clk_0) disable iff (wb_rst_i)
    strobe_n_i |-> ctrl_clk_i)
    else begin
      fail_cnt++;
      $error("adc_ctrl_clk_o low while adc_ctrl_strobe_n_o is high");
    end

  reset_values: assert property (@(posedge adc_clk_0)
    wb_rst_i |=> (!ack_i && !mode_i && !ddrb_i && strobe_n_i && ctrl_clk_i))
    else begin
      fail_cnt++;
      $error("control outputs not at their idle levels after reset");
    end

endmodule

bind iadc_top iadc_checker chk (
  .adc_clk_0  (adc_clk_0),
  .wb_rst_i   (wb_rst_i),
  .ack_i      (wb_ack_o),
  .mode_i     (adc_mode_o),
  .ddrb_i     (adc_ddrb_o),
  .ctrl_clk_i (adc_ctrl_clk_o),
  .strobe_n_i (adc_ctrl_strobe_n_o)
);

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // synchronous reset, released on a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- tb_iadc.sv
`timescale 1ns/1ps

module tb_iadc import iadc_pkg::*; ();

  localparam int CLK_PERIOD_NS   = 40;
  localparam int RESET_CYCLES    = 8;
  localparam int TWI_DIV_LOG2    = 3;
  localparam int FIFO_DEPTH_LOG2 = 3;
  localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_LOG2;
  localparam int ACK_LIMIT       = 16;   // cycles allowed for one ack
  localparam int XFER_CYCLES     = (TWI_WORD_W + 4) * (2 ** TWI_DIV_LOG2);
  localparam int BUS_OPS         = 120;  // bound on bus accesses outside the busy poll
  localparam int RUN_CYCLES      = RESET_CYCLES + 3 * BUS_OPS + 2 * XFER_CYCLES + 200;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_sel;
  logic [31:0] wb_adr;
  logic [15:0] wb_dat;
  logic [15:0] wb_rdata;
  logic        wb_ack;
  logic        adc_sync;
  logic        adc_ctrl_clk;
  logic        adc_ctrl_data;
  logic        adc_ctrl_strobe_n;
  logic        adc_mode;
  logic        adc_ddrb;

  logic [63:0] sample_cnt = 64'd0;       // fake adc data
  logic [31:0] lfsr = 32'h58d2_fa52;
  int          errors = 0;
  int          ddrb_count = 0;
  logic        ddrb_at_ack;
  logic [18:0] serial_bits = '0;
  int          serial_count = 0;

  tb_clkgen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clkgen (
    .clk_o (clk),
    .rst_o (rst)
  );

  iadc_top #(
    .TWI_DIV_LOG2    (TWI_DIV_LOG2),
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
  ) uut (
    .adc_clk_0           (clk),
    .wb_rst_i            (rst),
    .wb_cyc_i            (wb_cyc),
    .wb_stb_i            (wb_stb),
    .wb_we_i             (wb_we),
    .wb_sel_i            (wb_sel),
    .wb_adr_i            (wb_adr),
    .wb_dat_i            (wb_dat),
    .wb_dat_o            (wb_rdata),
    .wb_ack_o            (wb_ack),
    .adc_data_i          (sample_cnt),
    .adc_outofrange_i    (sample_cnt[3:0]),  // oor tracks the low data bits
    .adc_sync_i          (adc_sync),
    .adc_ctrl_clk_o      (adc_ctrl_clk),
    .adc_ctrl_data_o     (adc_ctrl_data),
    .adc_ctrl_strobe_n_o (adc_ctrl_strobe_n),
    .adc_mode_o          (adc_mode),
    .adc_ddrb_o          (adc_ddrb)
  );

  always @(posedge clk) sample_cnt <= sample_cnt + 64'd1;

  always @(negedge clk) begin
    if (adc_ddrb === 1'b1)
      ddrb_count++;
  end

  // adc side of the serial port samples on the rising serial clock
  always @(posedge adc_ctrl_clk) begin
    if (adc_ctrl_strobe_n === 1'b0) begin
      serial_bits = {serial_bits[17:0], adc_ctrl_data};
      serial_count++;
    end
  end

  function automatic logic [15:0] next_rand(input int nbits);
    logic [15:0] val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      val  = {val[14:0], lfsr[0]};
    end
    return val;
  endfunction

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL time=%0t %s got=%0h expected=%0h", $time, name, got, exp);
    end
  endtask

  task automatic require(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      errors++;
      $display("ERROR time=%0t %s", $time, what);
    end
  endtask

  task automatic bus_access(input logic is_write, input iadc_reg_e idx,
                            input logic [15:0] wdata, input logic [1:0] sel,
                            output logic [15:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= is_write;
    wb_sel <= sel;
    wb_adr <= {27'd0, idx, 1'b0};  // index sits on address bits 4..1
    wb_dat <= wdata;
    @(negedge clk);
    while (wb_ack !== 1'b1 && waited < ACK_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    require(wb_ack, "bus access got no ack");
    rdata       = wb_rdata;
    ddrb_at_ack = adc_ddrb;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input iadc_reg_e idx, input logic [15:0] data,
                           input logic [1:0] sel);
    logic [15:0] ignored;
    bus_access(1'b1, idx, data, sel, ignored);
  endtask

  task automatic read_reg(input iadc_reg_e idx, output logic [15:0] data);
    bus_access(1'b0, idx, 16'h0, 2'b11, data);
  endtask

  // head of the fifo, left in place
  task automatic read_head(output logic [SAMPLE_W-1:0] entry);
    logic [15:0] w;
    read_reg(REG_FIFODATA_4, w);
    entry[68:64] = w[4:0];
    read_reg(REG_FIFODATA_3, w);
    entry[63:48] = w;
    read_reg(REG_FIFODATA_2, w);
    entry[47:32] = w;
    read_reg(REG_FIFODATA_1, w);
    entry[31:16] = w;
    read_reg(REG_FIFODATA_0, w);
    entry[15:0] = w;
  endtask

  task automatic pop_entry(output logic [SAMPLE_W-1:0] entry);
    read_head(entry);
    write_reg(REG_FIFO_ADV, 16'h1, 2'b01);
  endtask

  task automatic fill_fifo();
    write_reg(REG_FIFO_CTRL, 16'h1, 2'b01);
    repeat (FIFO_DEPTH + 4) @(posedge clk);  // longer than the depth
    write_reg(REG_FIFO_CTRL, 16'h0, 2'b01);
  endtask

  task automatic registers_readback();
    logic [15:0] val;
    logic [15:0] first;
    logic [15:0] rd;
    val = next_rand(16);
    write_reg(REG_MODE, val, 2'b11);
    read_reg(REG_MODE, rd);
    compare("adc_mode", 64'(rd), 64'(val[0]));
    compare("adc_mode_o", 64'(adc_mode), 64'(val[0]));
    val = next_rand(16);
    write_reg(REG_TWI_ADDR, val, 2'b11);
    read_reg(REG_TWI_ADDR, rd);
    compare("twi_addr", 64'(rd), 64'(val[2:0]));
    first = next_rand(16);
    write_reg(REG_TWI_DATA, first, 2'b11);
    read_reg(REG_TWI_DATA, rd);
    compare("twi_data", 64'(rd), 64'(first));
    val = next_rand(16);
    write_reg(REG_TWI_DATA, val, 2'b01);  // low byte only
    read_reg(REG_TWI_DATA, rd);
    compare("twi_data_low", 64'(rd), 64'({first[15:8], val[7:0]}));
    first = {first[15:8], val[7:0]};
    val   = next_rand(16);
    write_reg(REG_TWI_DATA, val, 2'b10);
    read_reg(REG_TWI_DATA, rd);
    compare("twi_data_high", 64'(rd), 64'({val[15:8], first[7:0]}));
    val = next_rand(16);
    write_reg(REG_FIFO_CTRL, val, 2'b11);
    read_reg(REG_FIFO_CTRL, rd);
    compare("fifo_ctrl", 64'(rd), 64'(val[0]));
    write_reg(REG_FIFO_CTRL, 16'h0, 2'b01);
  endtask

  task automatic reset_strobe();
    logic [15:0] rd;
    int          start_count;
    write_reg(REG_MODE, 16'h1, 2'b01);  // mode high so a stray clear shows
    start_count = ddrb_count;
    write_reg(REG_RESET, 16'h1, 2'b01);
    require(ddrb_at_ack, "adc_ddrb was low during the ack of the reset write");
    repeat (4) @(posedge clk);
    compare("adc_ddrb_cycles", 64'(ddrb_count - start_count), 64'd1);
    read_reg(REG_MODE, rd);
    compare("adc_mode", 64'(rd), 64'd1);
    compare("adc_mode_o", 64'(adc_mode), 64'd1);
  endtask

  task automatic serial_transfer();
    logic [2:0]  addr;
    logic [15:0] data;
    logic [15:0] rd;
    int          start_count;
    int          polls;
    addr = 3'(next_rand(3));
    data = next_rand(16);
    write_reg(REG_TWI_ADDR, 16'(addr), 2'b01);
    write_reg(REG_TWI_DATA, data, 2'b11);
    start_count = serial_count;
    write_reg(REG_TWI_TX, 16'h1, 2'b01);
    read_reg(REG_TWI_TX, rd);
    compare("twi_busy", 64'(rd), 64'd1);
    write_reg(REG_TWI_TX, 16'h1, 2'b01);  // lands mid transfer
    polls = 0;
    read_reg(REG_TWI_TX, rd);
    while (rd[0] && polls < XFER_CYCLES) begin
      polls++;
      read_reg(REG_TWI_TX, rd);
    end
    compare("twi_busy", 64'(rd), 64'd0);
    repeat (2 ** TWI_DIV_LOG2) @(posedge clk);
    compare("serial_bit_count", 64'(serial_count - start_count), 64'(TWI_WORD_W));
    compare("serial_word", 64'(serial_bits), 64'({addr, data}));
  endtask

  task automatic capture_and_status();
    logic [SAMPLE_W-1:0] entry;
    logic [63:0]         prev;
    logic [63:0]         old_last;
    logic [15:0]         rd;
    @(posedge clk);
    adc_sync <= 1'b1;
    fill_fifo();
    read_reg(REG_FIFO_STATUS, rd);
    compare("fifo_status", 64'(rd), 64'(4'b1100));  // full, almost full
    prev = '0;
    for (int n = 0; n < FIFO_DEPTH; n++) begin
      pop_entry(entry);
      if (n > 0)
        compare("fifo_data", entry[63:0], prev + 64'd1);
      compare("fifo_outofrange", 64'(entry[67:64]), 64'(entry[3:0]));
      compare("fifo_sync", 64'(entry[68]), 64'd1);
      prev = entry[63:0];
    end
    read_reg(REG_FIFO_STATUS, rd);
    compare("fifo_status", 64'(rd), 64'(4'b0011));  // empty, almost empty
    fill_fifo();
    read_head(entry);
    old_last = entry[63:0] + 64'(FIFO_DEPTH - 1);
    write_reg(REG_FIFO_CTRL, 16'h1, 2'b01);
    write_reg(REG_FIFO_CTRL, 16'h0, 2'b01);
    read_reg(REG_FIFO_STATUS, rd);
    require(rd[3] == 1'b0 && rd[0] == 1'b0, "fifo not refilled fresh after re-enable");
    read_head(entry);
    require(entry[63:0] > old_last, "old fifo contents survived the re-enable");
  endtask

  task automatic activity_counter();
    logic [15:0] first;
    logic [15:0] second;
    logic [15:0] diff;
    read_reg(REG_CLKTEST0, first);
    read_reg(REG_CLKTEST0, second);
    diff = second - first;  // modulo 2^16 covers the wrap
    require(diff != 16'd0 && diff < 16'h8000, "activity counter did not advance");
  endtask

  initial begin
    repeat (RUN_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not finish", RUN_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int assert_errors;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_sel   = 2'b00;
    wb_adr   = 32'd0;
    wb_dat   = 16'd0;
    adc_sync = 1'b0;
    @(negedge rst);
    registers_readback();
    reset_strobe();
    serial_transfer();
    capture_and_status();
    activity_counter();
    repeat (2) @(posedge clk);
    assert_errors = uut.chk.fail_cnt;
    $display("done: %0d check errors, %0d assertion errors", errors, assert_errors);
    if (errors == 0 && assert_errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- src.f
iadc_pkg.sv
iadc_if.sv
iadc_regs.sv
twi_shifter.sv
adc_capture.sv
sample_fifo.sv
iadc_top.sv
iadc_checker.sv
tb_clkgen.sv
tb_iadc.sv

//--- Makefile
TOP := tb_iadc
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
